//--- filelist.f
logic/fft_types_pkg.sv
logic/fft_ctrl_pkg.sv
logic/sample_timer.sv
logic/adc_spi_capture.sv
logic/butterfly.sv
logic/fft_engine.sv
logic/fft_sequencer.sv
logic/fft_top.sv
tests/tb_clock.sv
tests/fft_tb.sv

//--- Makefile
TOP = fft_tb

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -f filelist.f

run: compile
	./obj_dir/V$(TOP) > run.log 2>&1; cat run.log
	@if grep -q "Test failures found" run.log; then \
		echo "Simulation failed"; exit 1; \
	elif ! grep -q "All tests passed!" run.log; then \
		echo "Simulation did not complete"; exit 1; \
	else \
		echo "Simulation passed"; \
	fi

clean:
	rm -rf obj_dir run.log

//--- tests/fft_tb.sv
// FFT subsystem testbench with an ADC serial model, a reference FFT and a four-phase ack responder
`default_nettype none
`timescale 1ns/1ps

module fft_tb
    import fft_types_pkg::*;
();

    localparam int NUM_FRAMES     = 4;
    localparam int DIRECTED_FRAME = 2;
    localparam int DIRECTED_CODE  = 200;
    localparam int WAIT_LIMIT     = 2000;
    localparam int TW_C [4] = '{127, 91, 0, -91};   // W(k) = c - j*s
    localparam int TW_S [4] = '{0, 91, 127, 91};

    logic        CLK;
    logic        reset;
    logic        adc_miso;
    logic        ack;
    logic        adc_cs_n;
    logic        adc_sclk;
    logic        req;
    cplx_t       result;
    bin_t        bin;

    logic [31:0] lfsr_state = 32'h3849_3b87;
    int          n_checks   = 0;
    int          n_errors   = 0;
    int          conv_count = 0;
    logic        sending    = 1'b0;     // Set between first req and last ack of a frame
    logic        timed_out  = 1'b0;
    adc_code_t   code_log [64];
    int          exp_re [FFT_POINTS];
    int          exp_im [FFT_POINTS];

    tb_clock u_clock (
        .CLK     (CLK),
        .o_reset (reset)
    );

    fft_top uut (
        .CLK        (CLK),
        .i_reset    (reset),
        .i_adc_miso (adc_miso),
        .i_ack      (ack),
        .o_adc_cs_n (adc_cs_n),
        .o_adc_sclk (adc_sclk),
        .o_req      (req),
        .o_result   (result),
        .o_bin      (bin)
    );

    // x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    function automatic int draw_bits(input int n);
        int v;
        v = 0;
        for (int i = 0; i < n; i++)
        begin
            lfsr_state = lfsr_step(lfsr_state);
            v = (v << 1) | int'(lfsr_state[0]);
        end
        return v;
    endfunction

    function automatic int bit_reverse(input int n);
        return ((n & 1) << 2) | (n & 2) | ((n >> 2) & 1);
    endfunction

    function automatic int twiddle_index(input int stage, input int pair);
        if (stage == 0)
            return 0;
        else if (stage == 1)
            return 2 * (pair % 2);
        return pair;
    endfunction

    function automatic int wrap_s8(input int v);
        logic signed [7:0] t;
        t = v[7:0];
        return int'(t);
    endfunction

    // Decimation in time, in place, four-multiply complex product
    task automatic build_reference(input int frame);
        int re [FFT_POINTS];
        int im [FFT_POINTS];
        int h;
        int top;
        int bot;
        int k;
        int pr;
        int pi;
        int ar;
        int ai;
        for (int n = 0; n < FFT_POINTS; n++)
        begin
            re[bit_reverse(n)] = int'(code_log[FFT_POINTS * frame + n]) - 128;
            im[bit_reverse(n)] = 0;
        end
        for (int s = 0; s < FFT_STAGES; s++)
        begin
            h = 1 << s;
            for (int p = 0; p < FFT_POINTS / 2; p++)
            begin
                top = (p / h) * 2 * h + (p % h);
                bot = top + h;
                k   = twiddle_index(s, p);
                pr  = (re[bot] * TW_C[k] + im[bot] * TW_S[k]) >>> TWIDDLE_FRAC;
                pi  = (im[bot] * TW_C[k] - re[bot] * TW_S[k]) >>> TWIDDLE_FRAC;
                ar  = re[top];
                ai  = im[top];
                re[top] = wrap_s8((ar + pr) >>> 1);
                im[top] = wrap_s8((ai + pi) >>> 1);
                re[bot] = wrap_s8((ar - pr) >>> 1);
                im[bot] = wrap_s8((ai - pi) >>> 1);
            end
        end
        for (int n = 0; n < FFT_POINTS; n++)
        begin
            exp_re[n] = re[n];
            exp_im[n] = im[n];
        end
    endtask

    task automatic compare_value(input string name, input int expected, input int actual);
        n_checks++;
        assert (actual == expected)
        else
        begin
            $display("FAIL at %0d ns: %s expected %0d, got %0d", $time, name, expected, actual);
            n_errors++;
        end
    endtask

    task automatic expect_true(input logic cond, input string msg);
        n_checks++;
        assert (cond)
        else
        begin
            $display("Error at %0d ns: %s", $time, msg);
            n_errors++;
        end
    endtask

    task automatic finish_run();
        $display("Checks run: %0d, errors: %0d", n_checks, n_errors);
        if (n_errors == 0)
            $display("All tests passed!");
        else
            $display("Test failures found");
        $finish;
    endtask

    task automatic report_timeout(input string what);
        n_errors++;
        timed_out = 1'b1;
        $display("Timed out after %0d cycles waiting for %s", WAIT_LIMIT, what);
    endtask

    task automatic check_held(input cplx_t held, input bin_t held_bin);
        compare_value("o_result.re", int'(held.re), int'(result.re));
        compare_value("o_result.im", int'(held.im), int'(result.im));
        compare_value("o_bin", int'(held_bin), int'(bin));
    endtask

    task automatic wait_for_req();
        int cycles;
        cycles = 0;
        do
        begin
            @(posedge CLK);
            #10;
            cycles++;
        end
        while (!req && cycles < WAIT_LIMIT);
        if (!req)
            report_timeout("o_req to rise");
    endtask

    task automatic wait_for_req_drop(input cplx_t held, input bin_t held_bin);
        int cycles;
        cycles = 0;
        do
        begin
            @(posedge CLK);
            #10;
            cycles++;
            if (req)
                check_held(held, held_bin);
        end
        while (req && cycles < WAIT_LIMIT);
        if (req)
            report_timeout("o_req to fall after i_ack");
    endtask

    task automatic watch_req_held(input int n, input cplx_t held, input bin_t held_bin);
        for (int i = 0; i < n; i++)
        begin
            @(posedge CLK);
            #10;
            expect_true(req, "o_req dropped before i_ack was raised");
            check_held(held, held_bin);
        end
    endtask

    task automatic watch_req_quiet(input int n);
        for (int i = 0; i < n; i++)
        begin
            @(posedge CLK);
            #10;
            expect_true(!req, "o_req rose again while i_ack was still high");
        end
    endtask

    // ADC model, MISO changes on CS fall and SCLK fall
    initial
    begin
        logic      cs_prev;
        logic      sclk_prev;
        adc_code_t code;
        int        bit_idx;
        int        rise_count;

        adc_miso   = 1'b0;
        cs_prev    = 1'b1;
        sclk_prev  = 1'b0;
        code       = '0;
        bit_idx    = 0;
        rise_count = 0;
        forever
        begin
            @(posedge CLK);
            #10;
            if (cs_prev && !adc_cs_n)
            begin
                expect_true(!sending, "ADC transfer started while results were being sent");
                if (conv_count / FFT_POINTS == DIRECTED_FRAME)
                    code = adc_code_t'(DIRECTED_CODE);
                else
                    code = adc_code_t'(draw_bits(8));
                if (conv_count < 64)
                    code_log[conv_count] = code;
                bit_idx    = 7;
                rise_count = 0;
                adc_miso   = code[7];
            end
            else if (!adc_cs_n)
            begin
                if (!sclk_prev && adc_sclk)
                    rise_count++;
                if (sclk_prev && !adc_sclk && bit_idx > 0)
                begin
                    bit_idx--;
                    adc_miso = code[bit_idx];
                end
            end
            else if (!cs_prev)
            begin
                compare_value("o_adc_sclk rising edges", 8, rise_count);  // End of conversion
                conv_count++;
            end
            cs_prev   = adc_cs_n;
            sclk_prev = adc_sclk;
        end
    end

    initial
    begin
        cplx_t held;
        bin_t  held_bin;
        int    delay;
        int    cycles;

        ack    = 1'b0;
        cycles = 0;
        do
        begin
            @(negedge CLK);
            cycles++;
        end
        while (reset !== 1'b0 && cycles < WAIT_LIMIT);
        if (reset !== 1'b0)
            report_timeout("reset release");
        else
        begin
            @(posedge CLK);
            #10;
            compare_value("o_req", 0, int'(req));
            compare_value("o_adc_sclk", 0, int'(adc_sclk));
            compare_value("o_adc_cs_n", 1, int'(adc_cs_n));

            for (int f = 0; f < NUM_FRAMES && !timed_out; f++)
            begin
                for (int b = 0; b < FFT_POINTS && !timed_out; b++)
                begin
                    wait_for_req();
                    if (!timed_out)
                    begin
                        if (b == 0)
                        begin
                            compare_value("ADC conversion count", FFT_POINTS * (f + 1),
                                          conv_count);
                            build_reference(f);
                            sending = 1'b1;
                        end
                        compare_value("o_bin", b, int'(bin));
                        compare_value("o_result.re", exp_re[b], int'(result.re));
                        compare_value("o_result.im", exp_im[b], int'(result.im));
                        if (f == DIRECTED_FRAME && b != 0)
                            compare_value("o_result", 0, int'(result));  // Constant input
                        held     = '{re: sample_t'(exp_re[b]), im: sample_t'(exp_im[b])};
                        held_bin = bin_t'(b);
                        delay    = draw_bits(3);
                        watch_req_held(delay, held, held_bin);
                        ack = 1'b1;
                        wait_for_req_drop(held, held_bin);
                        if (!timed_out)
                        begin
                            delay = draw_bits(3);
                            watch_req_quiet(delay);
                            ack = 1'b0;
                        end
                    end
                end
                sending = 1'b0;
            end
        end
        finish_run();
    end

endmodule

`default_nettype wire

//--- tests/tb_clock.sv
// Testbench clock and reset source, 100 ns period with reset held for three cycles
`default_nettype none
`timescale 1ns/1ps

module tb_clock (
    output logic CLK,
    output logic o_reset
);

    initial
    begin
        CLK     = 1'b0;
        o_reset = 1'b1;
        repeat (3) @(posedge CLK);
        #10 o_reset = 1'b0;     // Released off the edge like other inputs
    end

    always #50 CLK = ~CLK;

endmodule

`default_nettype wire

//--- logic/fft_top.sv
// FFT subsystem top joining the sample timer, SPI ADC capture, sequencer and engine
`default_nettype none
`timescale 1ns/1ps

module fft_top
    import fft_types_pkg::*;
(
    input  wire   CLK,
    input  wire   i_reset,
    input  wire   i_adc_miso,
    input  wire   i_ack,
    output logic  o_adc_cs_n,
    output logic  o_adc_sclk,
    output logic  o_req,
    output cplx_t o_result,
    output bin_t  o_bin
);

    logic    tick;
    logic    adc_start;
    logic    sample_valid;
    sample_t sample;
    logic    frame_full;
    logic    fft_start;
    logic    fft_done;
    bin_t    rd_addr;

    sample_timer u_timer (
        .CLK     (CLK),
        .i_reset (i_reset),
        .o_tick  (tick)
    );

    adc_spi_capture u_adc (
        .CLK            (CLK),
        .i_reset        (i_reset),
        .i_start        (adc_start),
        .i_adc_miso     (i_adc_miso),
        .o_adc_cs_n     (o_adc_cs_n),
        .o_adc_sclk     (o_adc_sclk),
        .o_sample_valid (sample_valid),
        .o_sample       (sample)
    );

    fft_sequencer u_seq (
        .CLK          (CLK),
        .i_reset      (i_reset),
        .i_tick       (tick),
        .i_frame_full (frame_full),
        .i_done       (fft_done),
        .i_ack        (i_ack),
        .o_adc_start  (adc_start),
        .o_start      (fft_start),
        .o_rd_addr    (rd_addr),
        .o_req        (o_req),
        .o_bin        (o_bin)
    );

    fft_engine u_engine (
        .CLK          (CLK),
        .i_reset      (i_reset),
        .i_load       (sample_valid),
        .i_load_data  (sample),
        .i_start      (fft_start),
        .i_rd_addr    (rd_addr),
        .o_frame_full (frame_full),
        .o_done       (fft_done),
        .o_rd_data    (o_result)
    );

endmodule

`default_nettype wire

//--- logic/fft_sequencer.sv
// Frame sequencer for capture, compute and four-phase result output
`default_nettype none
`timescale 1ns/1ps

module fft_sequencer
    import fft_types_pkg::*, fft_ctrl_pkg::*;
(
    input  wire  CLK,
    input  wire  i_reset,
    input  wire  i_tick,
    input  wire  i_frame_full,
    input  wire  i_done,
    input  wire  i_ack,
    output logic o_adc_start,
    output logic o_start,
    output bin_t o_rd_addr,
    output logic o_req,
    output bin_t o_bin
);

    seq_state_t state;
    bin_t       bin_cnt;

    // Ticks outside capture are dropped
    assign o_adc_start = (state == ST_CAPTURE) && i_tick;
    assign o_rd_addr   = bin_cnt;
    assign o_bin       = bin_cnt;

    always_ff @(posedge CLK)
    begin
        if (i_reset)
        begin
            state   <= ST_CAPTURE;
            bin_cnt <= '0;
            o_start <= 1'b0;
            o_req   <= 1'b0;
        end
        else
        begin
            o_start <= 1'b0;
            case (state)
                ST_CAPTURE:
                begin
                    if (i_frame_full)
                    begin
                        o_start <= 1'b1;
                        state   <= ST_COMPUTE;
                    end
                end
                ST_COMPUTE:
                begin
                    if (i_done)
                    begin
                        bin_cnt <= '0;
                        o_req   <= 1'b1;
                        state   <= ST_SEND_REQ;
                    end
                end
                ST_SEND_REQ:
                begin
                    if (i_ack)
                    begin
                        o_req <= 1'b0;
                        state <= ST_SEND_WAIT;
                    end
                end
                ST_SEND_WAIT:
                begin
                    if (!i_ack)
                    begin
                        if (bin_cnt == bin_t'(FFT_POINTS - 1))
                            state <= ST_CAPTURE;   // Frame sent
                        else
                        begin
                            bin_cnt <= bin_cnt + 1'b1;
                            o_req   <= 1'b1;
                            state   <= ST_SEND_REQ;
                        end
                    end
                end
                default: state <= ST_CAPTURE;
            endcase
        end
    end

    // New request only once the consumer has dropped ack
    a_req_rise: assert property (@(posedge CLK) disable iff (i_reset)
        $rose(o_req) |-> !$past(i_ack));

endmodule

`default_nettype wire

//--- logic/fft_engine.sv
// In-place 8-point FFT engine with bit-reversed load and one shared butterfly
`default_nettype none
`timescale 1ns/1ps

module fft_engine
    import fft_types_pkg::*;
(
    input  wire     CLK,
    input  wire     i_reset,
    input  wire     i_load,
    input  sample_t i_load_data,
    input  wire     i_start,
    input  bin_t    i_rd_addr,
    output logic    o_frame_full,
    output logic    o_done,
    output cplx_t   o_rd_data
);

    typedef logic [1:0] stage_t;
    typedef logic [1:0] pair_t;
    typedef struct packed {
        bin_t top;
        bin_t bot;
        logic last;
    } wb_tag_t;

    cplx_t   mem [FFT_POINTS];
    bin_t    load_ptr;
    stage_t  stage;
    pair_t   pair;
    logic    busy;
    logic    issuing;
    bin_t    rd_top;
    bin_t    rd_bot;
    pair_t   tw_k;
    wb_tag_t tag_d1;
    wb_tag_t tag_d2;
    logic    bf_valid;
    cplx_t   bf_d;
    cplx_t   bf_e;

    // DIT pair addressing, span doubles each stage
    always_comb
    begin
        case (stage)
            2'd0:
            begin
                rd_top = {pair, 1'b0};
                rd_bot = {pair, 1'b1};
                tw_k   = 2'd0;
            end
            2'd1:
            begin
                rd_top = {pair[1], 1'b0, pair[0]};
                rd_bot = {pair[1], 1'b1, pair[0]};
                tw_k   = {pair[0], 1'b0};
            end
            default:
            begin
                rd_top = {1'b0, pair};
                rd_bot = {1'b1, pair};
                tw_k   = pair;
            end
        endcase
    end

    always_ff @(posedge CLK)
    begin
        if (i_reset)
        begin
            load_ptr     <= '0;
            stage        <= '0;
            pair         <= '0;
            busy         <= 1'b0;
            issuing      <= 1'b0;
            o_frame_full <= 1'b0;
            o_done       <= 1'b0;
        end
        else
        begin
            o_frame_full <= i_load && (load_ptr == bin_t'(FFT_POINTS - 1));
            o_done       <= 1'b0;
            if (i_load)
                load_ptr <= load_ptr + 1'b1;    // Wraps after the eighth sample
            if (i_start && !busy)
            begin
                busy    <= 1'b1;
                issuing <= 1'b1;
                stage   <= '0;
                pair    <= '0;
            end
            else if (issuing)
            begin
                pair <= pair + 1'b1;
                if (pair == pair_t'(FFT_POINTS/2 - 1))
                    issuing <= 1'b0;
            end
            else if (bf_valid && tag_d2.last)
            begin
                // Stage drained
                if (stage == stage_t'(FFT_STAGES - 1))
                begin
                    busy   <= 1'b0;
                    o_done <= 1'b1;
                end
                else
                begin
                    stage   <= stage + 1'b1;
                    issuing <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge CLK)
    begin
        tag_d1 <= '{top: rd_top, bot: rd_bot, last: (pair == pair_t'(FFT_POINTS/2 - 1))};
        tag_d2 <= tag_d1;
        if (i_load)
            mem[{load_ptr[0], load_ptr[1], load_ptr[2]}] <= '{re: i_load_data, im: '0};
        else if (bf_valid)
        begin
            mem[tag_d2.top] <= bf_d;
            mem[tag_d2.bot] <= bf_e;
        end
    end

    butterfly u_butterfly (
        .CLK     (CLK),
        .i_reset (i_reset),
        .i_valid (issuing),
        .i_a     (mem[rd_top]),
        .i_b     (mem[rd_bot]),
        .i_tw    (TWIDDLE_ROM[tw_k]),
        .o_valid (bf_valid),
        .o_d     (bf_d),
        .o_e     (bf_e)
    );

    assign o_rd_data = mem[i_rd_addr];

    a_no_load_busy: assert property (@(posedge CLK) disable iff (i_reset)
        busy |-> !i_load);

endmodule

`default_nettype wire

//--- logic/butterfly.sv
// Radix-2 butterfly with three-multiplier twiddle product and scaling by one half
`default_nettype none
`timescale 1ns/1ps

module butterfly
    import fft_types_pkg::*;
(
    input  wire            CLK,
    input  wire            i_reset,
    input  wire            i_valid,
    input  cplx_t          i_a,
    input  cplx_t          i_b,
    input  twiddle_entry_t i_tw,
    output logic           o_valid,
    output cplx_t          o_d,
    output cplx_t          o_e
);

    logic signed [8:0]  b_sum;
    logic signed [17:0] m_c;    // c*(b.re + b.im)
    logic signed [17:0] m_cms;  // b.im*(c - s)
    logic signed [17:0] m_cps;  // b.re*(c + s)
    cplx_t              a_q;
    logic               valid_q;
    logic signed [17:0] p_re;
    logic signed [17:0] p_im;
    logic signed [17:0] d_re;
    logic signed [17:0] d_im;
    logic signed [17:0] e_re;
    logic signed [17:0] e_im;

    assign b_sum = i_b.re + i_b.im;

    always_ff @(posedge CLK)
    begin
        m_c   <= i_tw.c * b_sum;
        m_cms <= i_b.im * i_tw.cms;
        m_cps <= i_b.re * i_tw.cps;
        a_q   <= i_a;
    end

    always_comb
    begin
        p_re = (m_c - m_cms) >>> TWIDDLE_FRAC;
        p_im = (m_c - m_cps) >>> TWIDDLE_FRAC;
        d_re = (a_q.re + p_re) >>> 1;
        d_im = (a_q.im + p_im) >>> 1;
        e_re = (a_q.re - p_re) >>> 1;
        e_im = (a_q.im - p_im) >>> 1;
    end

    always_ff @(posedge CLK)
    begin
        o_d <= {d_re[7:0], d_im[7:0]};
        o_e <= {e_re[7:0], e_im[7:0]};
    end

    always_ff @(posedge CLK)
    begin
        if (i_reset)
        begin
            valid_q <= 1'b0;
            o_valid <= 1'b0;
        end
        else
        begin
            valid_q <= i_valid;
            o_valid <= valid_q;
        end
    end

    // Stored sums must match the cosine for the three-multiplier form
    a_twiddle_sums: assert property (@(posedge CLK) disable iff (i_reset)
        i_valid |-> (i_tw.cps + i_tw.cms == 2 * i_tw.c));

endmodule

`default_nettype wire

//--- logic/adc_spi_capture.sv
// SPI ADC capture reading one 8-bit code and delivering it as a signed sample
`default_nettype none
`timescale 1ns/1ps

module adc_spi_capture
    import fft_types_pkg::*, fft_ctrl_pkg::*;
(
    input  wire     CLK,
    input  wire     i_reset,
    input  wire     i_start,
    input  wire     i_adc_miso,
    output logic    o_adc_cs_n,
    output logic    o_adc_sclk,
    output logic    o_sample_valid,
    output sample_t o_sample
);

    typedef enum logic [1:0] {ADC_IDLE, ADC_SETUP, ADC_SHIFT} adc_state_t;
    typedef logic [$clog2(2*SCLK_HALF)-1:0] div_t;
    typedef logic [$clog2(ADC_BITS)-1:0] bit_idx_t;

    adc_state_t state;
    div_t       div_cnt;
    bit_idx_t   bit_cnt;
    adc_code_t  shreg;
    logic       bit_end;
    logic       sclk_rise;
    logic       xfer_end;

    assign bit_end   = (state == ADC_SHIFT) && (div_cnt == div_t'(2*SCLK_HALF - 1));
    assign xfer_end  = bit_end && (bit_cnt == bit_idx_t'(ADC_BITS - 1));
    assign sclk_rise = (state == ADC_SETUP) || (bit_end && !xfer_end);

    always_ff @(posedge CLK)
    begin
        if (i_reset)
        begin
            state          <= ADC_IDLE;
            o_adc_cs_n     <= 1'b1;
            o_adc_sclk     <= 1'b0;
            o_sample_valid <= 1'b0;
            div_cnt        <= '0;
            bit_cnt        <= '0;
        end
        else
        begin
            o_sample_valid <= xfer_end;
            case (state)
                ADC_IDLE:
                begin
                    if (i_start)
                    begin
                        o_adc_cs_n <= 1'b0;
                        state      <= ADC_SETUP;    // One cycle of setup with SCLK low
                    end
                end
                ADC_SETUP:
                begin
                    o_adc_sclk <= 1'b1;
                    div_cnt    <= '0;
                    bit_cnt    <= '0;
                    state      <= ADC_SHIFT;
                end
                ADC_SHIFT:
                begin
                    div_cnt <= div_cnt + 1'b1;
                    if (div_cnt == div_t'(SCLK_HALF - 1))
                        o_adc_sclk <= 1'b0;
                    if (xfer_end)
                    begin
                        o_adc_cs_n <= 1'b1;
                        state      <= ADC_IDLE;
                    end
                    else if (bit_end)
                    begin
                        o_adc_sclk <= 1'b1;
                        bit_cnt    <= bit_cnt + 1'b1;
                    end
                end
                default: state <= ADC_IDLE;
            endcase
        end
    end

    // MSB first, captured as SCLK goes high
    always_ff @(posedge CLK)
    begin
        if (sclk_rise)
            shreg <= {shreg[ADC_BITS-2:0], i_adc_miso};
        if (xfer_end)
            o_sample <= sample_t'({~shreg[ADC_BITS-1], shreg[ADC_BITS-2:0]});  // Code - 128
    end

    a_start_idle: assert property (@(posedge CLK) disable iff (i_reset)
        i_start |-> o_adc_cs_n);

endmodule

`default_nettype wire

//--- logic/sample_timer.sv
// Sample timer pulsing once per sample period to pace ADC conversions
`default_nettype none
`timescale 1ns/1ps

module sample_timer
    import fft_ctrl_pkg::*;
(
    input  wire  CLK,
    input  wire  i_reset,
    output logic o_tick
);

    typedef logic [$clog2(SAMPLE_PERIOD)-1:0] period_cnt_t;

    period_cnt_t cnt;

    always_ff @(posedge CLK)
    begin
        if (i_reset)
        begin
            cnt    <= '0;
            o_tick <= 1'b0;
        end
        else if (cnt == period_cnt_t'(SAMPLE_PERIOD - 1))
        begin
            cnt    <= '0;
            o_tick <= 1'b1;     // Pulse on wrap
        end
        else
        begin
            cnt    <= cnt + 1'b1;
            o_tick <= 1'b0;
        end
    end

endmodule

`default_nettype wire

//--- logic/fft_ctrl_pkg.sv
// FFT control package with sample pacing, SPI timing and sequencer states
`default_nettype none

package fft_ctrl_pkg;

    localparam int SAMPLE_PERIOD = 64;  // Cycles between ADC conversions
    localparam int SCLK_HALF     = 2;
    localparam int ADC_BITS      = 8;

    typedef enum logic [1:0] {
        ST_CAPTURE,
        ST_COMPUTE,
        ST_SEND_REQ,
        ST_SEND_WAIT
    } seq_state_t;

endpackage

`default_nettype wire

//--- logic/fft_types_pkg.sv
// FFT data path package with sample and twiddle types, complex struct and twiddle table
`default_nettype none

package fft_types_pkg;

    typedef logic signed [7:0] sample_t;
    typedef logic        [7:0] adc_code_t;
    typedef logic        [2:0] bin_t;
    typedef logic signed [7:0] twiddle_t;       // Q1.7
    typedef logic signed [8:0] twiddle_sum_t;   // c+s or c-s

    typedef struct packed {
        sample_t re;
        sample_t im;
    } cplx_t;

    typedef struct packed {
        twiddle_t     c;
        twiddle_sum_t cps;
        twiddle_sum_t cms;
    } twiddle_entry_t;

    localparam int FFT_POINTS   = 8;
    localparam int FFT_STAGES   = 3;
    localparam int TWIDDLE_FRAC = 7;

    // W(k) = c - j*s, k = 0..3
    localparam twiddle_entry_t TWIDDLE_ROM [FFT_POINTS/2] = '{
        '{c: 8'sd127, cps: 9'sd127, cms: 9'sd127},
        '{c: 8'sd91,  cps: 9'sd182, cms: 9'sd0},
        '{c: 8'sd0,   cps: 9'sd127, cms: -9'sd127},
        '{c: -8'sd91, cps: 9'sd0,   cms: -9'sd182}
    };

endpackage

`default_nettype wire
